/* spmm_pkg.sv */
`default_nettype none

package spmm_pkg;

  // array geometry
  localparam int W_NUM_COLS       = 4;
  localparam int DATA_W           = 16;
  localparam int COL_IDX_W        = 6;

  // node info fields
  localparam int ROW_LEN_W        = 5;
  localparam int NUM_NODE_W       = 5;

  // memory address widths
  localparam int H_ADDR_W         = 8;
  localparam int NODE_INFO_ADDR_W = 6;
  localparam int WH_ADDR_W        = 6;

  // column accumulator, wraps on overflow
  localparam int WH_DATA_W        = 32;

  // node info prefetch queue
  localparam int FIFO_DEPTH       = 4;
  localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W       = $clog2(FIFO_DEPTH + 1);

  // one nonzero of H
  typedef struct packed {
    logic        [COL_IDX_W-1:0] col_idx;
    logic signed [DATA_W-1:0]    value;
  } h_data_t;

  typedef struct packed {
    logic [ROW_LEN_W-1:0]  row_length;
    logic [NUM_NODE_W-1:0] num_of_nodes;
    logic                  source_flag;
  } node_info_t;

  // column 0 lands in the top bits
  typedef struct packed {
    logic [0:W_NUM_COLS-1][WH_DATA_W-1:0] results;
    logic [NUM_NODE_W-1:0]                num_of_nodes;
    logic                                 source_flag;
  } wh_t;

endpackage

`default_nettype wire

/* pe_bus_if.sv */
`default_nettype none

// nonzero stream, broadcast to every processing element
interface pe_bus_if;

  logic                                valid;
  logic [spmm_pkg::COL_IDX_W-1:0]      col_idx;
  logic signed [spmm_pkg::DATA_W-1:0]  value;
  // final nonzero of the row
  logic                                last;

  modport ctrl (
    output valid,
    output col_idx,
    output value,
    output last
  );

  modport pe (
    input valid,
    input col_idx,
    input value,
    input last
  );

endinterface

`default_nettype wire

/* node_info_fifo.sv */
`default_nettype none

module node_info_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push_i,
  input  spmm_pkg::node_info_t din_i,
  input  logic                 pop_i,
  output spmm_pkg::node_info_t dout_o,
  output logic                 full_o,
  output logic                 empty_o
);

  spmm_pkg::node_info_t              mem [spmm_pkg::FIFO_DEPTH];
  logic [spmm_pkg::FIFO_PTR_W-1:0]   wr_ptr;
  logic [spmm_pkg::FIFO_PTR_W-1:0]   rd_ptr;
  logic [spmm_pkg::FIFO_CNT_W-1:0]   count;
  logic                              do_push;
  logic                              do_pop;

  function automatic logic [spmm_pkg::FIFO_PTR_W-1:0] next_ptr(
    input logic [spmm_pkg::FIFO_PTR_W-1:0] ptr
  );
    if (ptr == spmm_pkg::FIFO_DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count == spmm_pkg::FIFO_DEPTH);
  assign empty_o = (count == 0);
  // head is visible without a pop
  assign dout_o  = mem[rd_ptr];

  assign do_pop  = pop_i && !empty_o;
  // a full queue still takes a word when one leaves
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* spmm_ctrl.sv */
`default_nettype none

module spmm_ctrl (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start_i,
  input  logic [spmm_pkg::NODE_INFO_ADDR_W-1:0] num_rows_i,
  output logic [spmm_pkg::NODE_INFO_ADDR_W-1:0] node_info_addr_o,
  input  spmm_pkg::node_info_t                  node_info_data_i,
  output logic [spmm_pkg::H_ADDR_W-1:0]         h_addr_o,
  input  spmm_pkg::h_data_t                     h_data_i,
  output logic                                  fifo_push_o,
  output logic                                  fifo_pop_o,
  input  spmm_pkg::node_info_t                  fifo_head_i,
  input  logic                                  fifo_full_i,
  input  logic                                  fifo_empty_i,
  pe_bus_if.ctrl                                bus,
  output spmm_pkg::node_info_t                  row_meta_o,
  input  logic [spmm_pkg::WH_ADDR_W-1:0]        rows_written_i,
  output logic                                  busy_o,
  output logic                                  done_o
);

  logic                                  busy_q;
  logic                                  job_start;
  logic                                  job_end;
  logic [spmm_pkg::NODE_INFO_ADDR_W-1:0] num_rows_q;
  logic [spmm_pkg::NODE_INFO_ADDR_W-1:0] ni_left_q;
  logic [spmm_pkg::FIFO_CNT_W-1:0]       ni_held_q;
  logic                                  ni_issue;
  logic                                  ni_pend_q;
  spmm_pkg::node_info_t                  head;
  logic                                  row_start;
  logic [spmm_pkg::ROW_LEN_W-1:0]        elem_left_q;
  logic                                  h_issue;
  logic                                  h_last;
  spmm_pkg::node_info_t                  meta_cur_q;

  // job ends once the writer has stored every row
  assign job_end   = busy_q && (rows_written_i == num_rows_q);
  assign busy_o    = busy_q && !job_end;
  assign done_o    = job_end;
  assign job_start = start_i && !busy_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      num_rows_q <= '0;
    end else if (job_start) begin
      busy_q     <= 1'b1;
      num_rows_q <= num_rows_i;
    end else if (job_end) begin
      busy_q <= 1'b0;
    end
  end

  // node info prefetch, words fetched but not yet started stay within the queue depth
  assign ni_issue = busy_q && (ni_left_q != 0) && !fifo_full_i &&
                    (ni_held_q < spmm_pkg::FIFO_DEPTH);

  // oldest word is in the queue, or arriving from memory when the queue is empty
  assign head        = fifo_empty_i ? node_info_data_i : fifo_head_i;
  assign row_start   = busy_q && (elem_left_q == 0) && (!fifo_empty_i || ni_pend_q);
  assign fifo_pop_o  = row_start && !fifo_empty_i;
  assign fifo_push_o = ni_pend_q && !(row_start && fifo_empty_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_info_addr_o <= '0;
      ni_left_q        <= '0;
      ni_pend_q        <= 1'b0;
      ni_held_q        <= '0;
    end else if (job_start) begin
      node_info_addr_o <= '0;
      ni_left_q        <= num_rows_i;
      ni_pend_q        <= 1'b0;
      ni_held_q        <= '0;
    end else begin
      ni_pend_q <= ni_issue;
      if (ni_issue) begin
        node_info_addr_o <= node_info_addr_o + 1'b1;
        ni_left_q        <= ni_left_q - 1'b1;
      end
      if (ni_issue && !row_start) begin
        ni_held_q <= ni_held_q + 1'b1;
      end else if (!ni_issue && row_start) begin
        ni_held_q <= ni_held_q - 1'b1;
      end
    end
  end

  // nonzero walk
  assign h_issue = row_start || (elem_left_q != 0);
  assign h_last  = row_start ? (head.row_length == 1) : (elem_left_q == 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_addr_o    <= '0;
      elem_left_q <= '0;
    end else if (job_start) begin
      h_addr_o    <= '0;
      elem_left_q <= '0;
    end else begin
      if (h_issue) begin
        h_addr_o <= h_addr_o + 1'b1;
      end
      if (row_start) begin
        elem_left_q <= head.row_length - 1'b1;
      end else if (elem_left_q != 0) begin
        elem_left_q <= elem_left_q - 1'b1;
      end
    end
  end

  // memory data lines up with the delayed strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.valid <= 1'b0;
      bus.last  <= 1'b0;
    end else begin
      bus.valid <= h_issue;
      bus.last  <= h_last;
    end
  end

  assign bus.col_idx = h_data_i.col_idx;
  assign bus.value   = h_data_i.value;

  // metadata handed to the writer as the row's final nonzero is fetched
  always_ff @(posedge clk) begin
    if (row_start) begin
      meta_cur_q <= head;
    end
    if (h_last) begin
      row_meta_o <= row_start ? head : meta_cur_q;
    end
  end

endmodule

`default_nettype wire

/* sp_pe.sv */
`default_nettype none

module sp_pe (
  input  logic                                  clk,
  input  logic                                  rst_n,
  pe_bus_if.pe                                  bus,
  output logic [spmm_pkg::COL_IDX_W-1:0]        weight_addr_o,
  input  logic signed [spmm_pkg::DATA_W-1:0]    weight_data_i,
  output logic signed [spmm_pkg::WH_DATA_W-1:0] result_o,
  output logic                                  result_valid_o
);

  logic                                  valid_q;
  logic                                  last_q;
  logic signed [spmm_pkg::DATA_W-1:0]    value_q;
  logic signed [spmm_pkg::WH_DATA_W-1:0] value_ext;
  logic signed [spmm_pkg::WH_DATA_W-1:0] weight_ext;
  logic signed [spmm_pkg::WH_DATA_W-1:0] product;
  logic signed [spmm_pkg::WH_DATA_W-1:0] acc_sum;
  logic signed [spmm_pkg::WH_DATA_W-1:0] acc_q;

  // weight row lookup, data returns next cycle
  assign weight_addr_o = bus.col_idx;

  always_ff @(posedge clk) begin
    value_q <= bus.value;
  end

  assign value_ext  = {{(spmm_pkg::WH_DATA_W - spmm_pkg::DATA_W){value_q[spmm_pkg::DATA_W-1]}},
                       value_q};
  assign weight_ext = {{(spmm_pkg::WH_DATA_W - spmm_pkg::DATA_W){weight_data_i[spmm_pkg::DATA_W-1]}},
                       weight_data_i};
  assign product    = value_ext * weight_ext;
  assign acc_sum    = acc_q + product;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q        <= 1'b0;
      last_q         <= 1'b0;
      acc_q          <= '0;
      result_valid_o <= 1'b0;
    end else begin
      valid_q        <= bus.valid;
      last_q         <= bus.last;
      result_valid_o <= valid_q && last_q;
      if (valid_q) begin
        // row done, next row begins from zero
        acc_q <= last_q ? '0 : acc_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_q && last_q) begin
      result_o <= acc_sum;
    end
  end

endmodule

`default_nettype wire

/* wh_writer.sv */
`default_nettype none

module wh_writer (
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  input  logic                                                       start_i,
  input  logic [spmm_pkg::W_NUM_COLS-1:0][spmm_pkg::WH_DATA_W-1:0]   result_i,
  input  logic                                                       result_valid_i,
  input  spmm_pkg::node_info_t                                       row_meta_i,
  output logic                                                       wh_we_o,
  output logic [spmm_pkg::WH_ADDR_W-1:0]                             wh_addr_o,
  output spmm_pkg::wh_t                                              wh_data_o,
  output logic [spmm_pkg::WH_ADDR_W-1:0]                             rows_written_o
);

  spmm_pkg::node_info_t           meta_q [2];
  logic [spmm_pkg::WH_ADDR_W-1:0] addr_q;

  // metadata trails the PE pipeline by two stages
  always_ff @(posedge clk) begin
    meta_q[0] <= row_meta_i;
    meta_q[1] <= meta_q[0];
  end

  always_comb begin
    for (int c = 0; c < spmm_pkg::W_NUM_COLS; c++) begin
      wh_data_o.results[c] = result_i[c];
    end
    wh_data_o.num_of_nodes = meta_q[1].num_of_nodes;
    wh_data_o.source_flag  = meta_q[1].source_flag;
  end

  assign wh_we_o = result_valid_i;

  // address doubles as the row count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (start_i) begin
      addr_q <= '0;
    end else if (result_valid_i) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign wh_addr_o      = addr_q;
  assign rows_written_o = addr_q;

endmodule

`default_nettype wire

/* spmm_top.sv */
`default_nettype none

module spmm_top (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      start_i,
  input  logic [spmm_pkg::NODE_INFO_ADDR_W-1:0]                     num_rows_i,
  output logic [spmm_pkg::H_ADDR_W-1:0]                             h_addr_o,
  input  spmm_pkg::h_data_t                                         h_data_i,
  output logic [spmm_pkg::NODE_INFO_ADDR_W-1:0]                     node_info_addr_o,
  input  spmm_pkg::node_info_t                                      node_info_data_i,
  output logic [spmm_pkg::W_NUM_COLS-1:0][spmm_pkg::COL_IDX_W-1:0]  weight_addr_o,
  input  logic [spmm_pkg::W_NUM_COLS-1:0][spmm_pkg::DATA_W-1:0]     weight_data_i,
  output logic                                                      wh_we_o,
  output logic [spmm_pkg::WH_ADDR_W-1:0]                            wh_addr_o,
  output spmm_pkg::wh_t                                             wh_data_o,
  output logic                                                      busy_o,
  output logic                                                      done_o
);

  logic                                                     fifo_push;
  logic                                                     fifo_pop;
  logic                                                     fifo_full;
  logic                                                     fifo_empty;
  spmm_pkg::node_info_t                                     fifo_head;
  spmm_pkg::node_info_t                                     row_meta;
  logic [spmm_pkg::WH_ADDR_W-1:0]                           rows_written;
  logic [spmm_pkg::W_NUM_COLS-1:0][spmm_pkg::WH_DATA_W-1:0] pe_result;
  logic [spmm_pkg::W_NUM_COLS-1:0]                          pe_result_valid;
  logic                                                     writer_start;

  pe_bus_if pe_bus ();

  // a start during a job is ignored
  assign writer_start = start_i & ~busy_o;

  spmm_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (start_i),
    .num_rows_i       (num_rows_i),
    .node_info_addr_o (node_info_addr_o),
    .node_info_data_i (node_info_data_i),
    .h_addr_o         (h_addr_o),
    .h_data_i         (h_data_i),
    .fifo_push_o      (fifo_push),
    .fifo_pop_o       (fifo_pop),
    .fifo_head_i      (fifo_head),
    .fifo_full_i      (fifo_full),
    .fifo_empty_i     (fifo_empty),
    .bus              (pe_bus),
    .row_meta_o       (row_meta),
    .rows_written_i   (rows_written),
    .busy_o           (busy_o),
    .done_o           (done_o)
  );

  node_info_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (fifo_push),
    .din_i   (node_info_data_i),
    .pop_i   (fifo_pop),
    .dout_o  (fifo_head),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // one PE per weight column
  for (genvar c = 0; c < spmm_pkg::W_NUM_COLS; c++) begin : g_pe
    sp_pe u_pe (
      .clk            (clk),
      .rst_n          (rst_n),
      .bus            (pe_bus),
      .weight_addr_o  (weight_addr_o[c]),
      .weight_data_i  (weight_data_i[c]),
      .result_o       (pe_result[c]),
      .result_valid_o (pe_result_valid[c])
    );
  end

  // PEs run in lockstep
  wh_writer u_writer (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (writer_start),
    .result_i       (pe_result),
    .result_valid_i (&pe_result_valid),
    .row_meta_i     (row_meta),
    .wh_we_o        (wh_we_o),
    .wh_addr_o      (wh_addr_o),
    .wh_data_o      (wh_data_o),
    .rows_written_o (rows_written)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    #(PERIOD * RESET_CYCLES);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* spmm_checker.sv */
`default_nettype none

module spmm_checker (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           start_i,
  input logic                           busy_i,
  input logic                           done_i,
  input logic                           wh_we_i,
  input logic [spmm_pkg::WH_ADDR_W-1:0] wh_addr_i
);

  // writes only inside a job
  we_in_job: assert property (@(posedge clk) disable iff (!rst_n) wh_we_i |-> busy_i)
    else $error("wh_we_o high while busy_o is low");

  done_single: assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
    else $error("done_o held high for more than one cycle");

  // address steps on a write, or goes back to zero on a new job
  addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(wh_addr_i) |-> ($past(wh_we_i) || $past(start_i && !busy_i)))
    else $error("wh_addr_o changed without a write");

endmodule

bind spmm_top spmm_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .start_i   (start_i),
  .busy_i    (busy_o),
  .done_i    (done_o),
  .wh_we_i   (wh_we_o),
  .wh_addr_i (wh_addr_o)
);

`default_nettype wire

/* spmm_tb.sv */
`default_nettype none

module spmm_tb;

  localparam int NUM_TESTS = 4;
  localparam int MAX_ROWS  = 10;
  localparam int CAP_DEPTH = 2 ** spmm_pkg::WH_ADDR_W;
  localparam int W_ROWS    = 2 ** spmm_pkg::COL_IDX_W;

  logic                                                     clk;
  logic                                                     rst_n;
  logic                                                     start_i;
  logic [spmm_pkg::NODE_INFO_ADDR_W-1:0]                    num_rows;
  logic [spmm_pkg::H_ADDR_W-1:0]                            h_addr;
  spmm_pkg::h_data_t                                        h_data;
  logic [spmm_pkg::NODE_INFO_ADDR_W-1:0]                    ni_addr;
  spmm_pkg::node_info_t                                     ni_data;
  logic [spmm_pkg::W_NUM_COLS-1:0][spmm_pkg::COL_IDX_W-1:0] weight_addr;
  logic [spmm_pkg::W_NUM_COLS-1:0][spmm_pkg::DATA_W-1:0]    weight_data;
  logic                                                     wh_we;
  logic [spmm_pkg::WH_ADDR_W-1:0]                           wh_addr;
  spmm_pkg::wh_t                                            wh_data;
  logic                                                     busy;
  logic                                                     done;

  // stimulus table, per test name and row count, per row length, node count and flag
  string test_name [NUM_TESTS] = '{"single_nz", "long_rows", "many_short", "restart"};
  int test_rows [NUM_TESTS] = '{4, 3, 10, 5};
  int row_len [NUM_TESTS][MAX_ROWS] = '{
    '{1, 1, 1, 1, 0, 0, 0, 0, 0, 0},
    '{20, 17, 9, 0, 0, 0, 0, 0, 0, 0},
    '{1, 2, 1, 3, 1, 1, 2, 1, 1, 2},
    '{5, 1, 8, 2, 4, 0, 0, 0, 0, 0}
  };
  int row_nodes [NUM_TESTS][MAX_ROWS] = '{
    '{3, 7, 1, 30, 0, 0, 0, 0, 0, 0},
    '{12, 5, 19, 0, 0, 0, 0, 0, 0, 0},
    '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10},
    '{31, 0, 15, 2, 9, 0, 0, 0, 0, 0}
  };
  int row_flag [NUM_TESTS][MAX_ROWS] = '{
    '{1, 0, 1, 1, 0, 0, 0, 0, 0, 0},
    '{0, 1, 1, 0, 0, 0, 0, 0, 0, 0},
    '{1, 0, 0, 1, 0, 1, 1, 0, 0, 1},
    '{0, 1, 0, 1, 1, 0, 0, 0, 0, 0}
  };

  spmm_pkg::h_data_t           h_mem  [2 ** spmm_pkg::H_ADDR_W];
  spmm_pkg::node_info_t        ni_mem [2 ** spmm_pkg::NODE_INFO_ADDR_W];
  logic [spmm_pkg::DATA_W-1:0] w_mem  [spmm_pkg::W_NUM_COLS][W_ROWS];
  int                          exp_res [MAX_ROWS][spmm_pkg::W_NUM_COLS];
  logic [15:0]                 lfsr_q;

  // writes seen on the WH port, counted over all jobs
  logic [spmm_pkg::WH_ADDR_W-1:0] cap_addr [CAP_DEPTH];
  spmm_pkg::wh_t                  cap_data [CAP_DEPTH];
  int                             wr_count  = 0;
  int                             done_cnt  = 0;
  int                             done_mark = 0;

  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  spmm_top spmm_top_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (start_i),
    .num_rows_i       (num_rows),
    .h_addr_o         (h_addr),
    .h_data_i         (h_data),
    .node_info_addr_o (ni_addr),
    .node_info_data_i (ni_data),
    .weight_addr_o    (weight_addr),
    .weight_data_i    (weight_data),
    .wh_we_o          (wh_we),
    .wh_addr_o        (wh_addr),
    .wh_data_o        (wh_data),
    .busy_o           (busy),
    .done_o           (done)
  );

  // memories with one cycle of read latency
  always @(posedge clk) begin
    h_data  <= h_mem[h_addr];
    ni_data <= ni_mem[ni_addr];
    for (int c = 0; c < spmm_pkg::W_NUM_COLS; c++) begin
      weight_data[c] <= w_mem[c][weight_addr[c]];
    end
  end

  always @(posedge clk) begin
    if (wh_we) begin
      if (wr_count < CAP_DEPTH) begin
        cap_addr[wr_count] = wh_addr;
        cap_data[wr_count] = wh_data;
      end
      wr_count = wr_count + 1;
    end
    if (done) begin
      done_cnt  = done_cnt + 1;
      done_mark = wr_count;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %0d actual %0d", name, $signed(expected),
               $signed(actual));
      $display("*** FAILED ***");
      $fatal(1, "value check failed");
    end
  endtask

  // fills the memories and works out the expected sums
  task automatic load_job(input int t);
    int                addr;
    logic [31:0]       bits;
    spmm_pkg::h_data_t nz;
    for (int c = 0; c < spmm_pkg::W_NUM_COLS; c++) begin
      for (int a = 0; a < W_ROWS; a++) begin
        draw_bits(spmm_pkg::DATA_W, bits);
        w_mem[c][a] = bits[spmm_pkg::DATA_W-1:0];
      end
    end
    addr = 0;
    for (int r = 0; r < test_rows[t]; r++) begin
      ni_mem[r].row_length   = row_len[t][r][spmm_pkg::ROW_LEN_W-1:0];
      ni_mem[r].num_of_nodes = row_nodes[t][r][spmm_pkg::NUM_NODE_W-1:0];
      ni_mem[r].source_flag  = row_flag[t][r][0];
      for (int c = 0; c < spmm_pkg::W_NUM_COLS; c++) begin
        exp_res[r][c] = 0;
      end
      for (int k = 0; k < row_len[t][r]; k++) begin
        draw_bits(spmm_pkg::COL_IDX_W, bits);
        nz.col_idx = bits[spmm_pkg::COL_IDX_W-1:0];
        draw_bits(spmm_pkg::DATA_W, bits);
        nz.value    = bits[spmm_pkg::DATA_W-1:0];
        h_mem[addr] = nz;
        addr        = addr + 1;
        // int arithmetic wraps at 32 bits like the accumulator
        for (int c = 0; c < spmm_pkg::W_NUM_COLS; c++) begin
          exp_res[r][c] += int'($signed(nz.value)) * int'($signed(w_mem[c][nz.col_idx]));
        end
      end
    end
  endtask

  task automatic run_job(input int t);
    int    base;
    int    jobs_before;
    string tag;
    load_job(t);
    base        = wr_count;
    jobs_before = done_cnt;
    @(negedge clk);
    num_rows = test_rows[t][spmm_pkg::NODE_INFO_ADDR_W-1:0];
    start_i  = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    check_value({test_name[t], " busy after start"}, 32'd1, 32'(busy));
    // the watchdog ends this wait if done never comes
    while (done_cnt == jobs_before) begin
      @(negedge clk);
    end
    check_value({test_name[t], " writes before done"}, 32'(test_rows[t]),
                32'(done_mark - base));
    for (int k = 0; k < test_rows[t]; k++) begin
      tag = $sformatf("%s row %0d", test_name[t], k);
      check_value({tag, " addr"}, 32'(k), 32'(cap_addr[base + k]));
      for (int c = 0; c < spmm_pkg::W_NUM_COLS; c++) begin
        check_value($sformatf("%s col %0d", tag, c), 32'(exp_res[k][c]),
                    32'(cap_data[base + k].results[c]));
      end
      check_value({tag, " nodes"}, 32'(row_nodes[t][k]),
                  32'(cap_data[base + k].num_of_nodes));
      check_value({tag, " flag"}, 32'(row_flag[t][k]), 32'(cap_data[base + k].source_flag));
    end
    repeat (4) @(negedge clk);
    check_value({test_name[t], " done pulses"}, 32'(jobs_before + 1), 32'(done_cnt));
    check_value({test_name[t], " write count"}, 32'(base + test_rows[t]), 32'(wr_count));
    check_value({test_name[t], " busy after done"}, 32'd0, 32'(busy));
  endtask

  // cycles allowed for the whole run
  function automatic int timeout_cycles();
    int total;
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += test_rows[t];
      for (int r = 0; r < MAX_ROWS; r++) begin
        total += row_len[t][r];
      end
    end
    return total * 4 + NUM_TESTS * 20 + 100;
  endfunction

  initial begin : watchdog
    int limit;
    limit = timeout_cycles();
    repeat (limit) @(posedge clk);
    $display("timeout, the jobs did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    lfsr_q      = 16'd62893;
    start_i     = 1'b0;
    num_rows    = '0;
    h_data      = '0;
    ni_data     = '0;
    weight_data = '0;
    for (int a = 0; a < 2 ** spmm_pkg::H_ADDR_W; a++) begin
      h_mem[a] = '0;
    end
    for (int a = 0; a < 2 ** spmm_pkg::NODE_INFO_ADDR_W; a++) begin
      ni_mem[a] = '0;
    end
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value("reset busy", 32'd0, 32'(busy));
    check_value("reset done", 32'd0, 32'(done));
    check_value("reset wh_we", 32'd0, 32'(wh_we));
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_job(t);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* spmm_top.f */
spmm_pkg.sv
pe_bus_if.sv
node_info_fifo.sv
spmm_ctrl.sv
sp_pe.sv
wh_writer.sv
spmm_top.sv
tb_clock_gen.sv
spmm_checker.sv
spmm_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= spmm_tb
LINT_TOP  ?= spmm_top
FILELIST  ?= spmm_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
